// File: project.f
hdl/prf_cfg_pkg.sv
hdl/prf_bus_pkg.sv
hdl/prf_free_alloc.sv
hdl/prf_free_ctrl.sv
hdl/prf_entry_array.sv
hdl/prf_operand_read.sv
hdl/prf.sv
sim/prf_tb.sv

// File: Makefile
# Verilator build and run of the physical register file testbench

VERILATOR ?= verilator
TOP       ?= prf_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal
FAIL_MSG  ?= Verification failed
PASS_MSG  ?= Verification passed

SIM_EXE = $(OBJ_DIR)/V$(TOP)
SOURCES = $(wildcard hdl/*.sv) $(wildcard sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_EXE)

$(SIM_EXE): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-$(SIM_EXE) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported an error"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/prf_tb.sv
////////////////////////////////////////////////////////////
// testbench of the physical register file
// LFSR stimulus against a bitmap and data reference model
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module prf_tb;

	logic                        clock;
	logic                        rst;
	prf_bus_pkg::cdb_t           cdb1;
	prf_bus_pkg::cdb_t           cdb2;
	prf_cfg_pkg::prf_idx_t       opa1_idx;
	prf_cfg_pkg::prf_idx_t       opb1_idx;
	prf_cfg_pkg::prf_idx_t       opa2_idx;
	prf_cfg_pkg::prf_idx_t       opb2_idx;
	prf_bus_pkg::alloc_req_t     alloc;
	prf_bus_pkg::retire_free_t   retire1;
	prf_bus_pkg::retire_free_t   retire2;
	prf_bus_pkg::recover_t       recover1;
	prf_bus_pkg::recover_t       recover2;
	prf_bus_pkg::rename_grants_t grants;
	prf_bus_pkg::operand_t       opa1;
	prf_bus_pkg::operand_t       opb1;
	prf_bus_pkg::operand_t       opa2;
	prf_bus_pkg::operand_t       opb2;
	logic                        prf_is_full;

	prf_cfg_pkg::prf_mask_t      free_m;    // model free bitmap
	prf_cfg_pkg::prf_mask_t      ready_m;   // model ready bitmap
	prf_cfg_pkg::prf_data_t      data_m [prf_cfg_pkg::PRF_SIZE];
	prf_bus_pkg::rename_grants_t exp_grants;
	prf_cfg_pkg::prf_mask_t      exp_alloc_mask;
	prf_cfg_pkg::prf_mask_t      exp_free_mask;
	prf_cfg_pkg::prf_mask_t      wr_mask;   // entries hit by either bus
	prf_bus_pkg::operand_t       exp_opa1;
	prf_bus_pkg::operand_t       exp_opb1;
	prf_bus_pkg::operand_t       exp_opa2;
	prf_bus_pkg::operand_t       exp_opb2;
	logic [31:0]                 lfsr_state;

	prf i_prf (
		.clock(clock), .rst(rst), .cdb1(cdb1), .cdb2(cdb2),
		.opa1_idx(opa1_idx), .opb1_idx(opb1_idx), .opa2_idx(opa2_idx), .opb2_idx(opb2_idx),
		.alloc(alloc), .retire1(retire1), .retire2(retire2),
		.recover1(recover1), .recover2(recover2), .grants(grants),
		.opa1(opa1), .opb1(opb1), .opa2(opa2), .opb2(opb2), .prf_is_full(prf_is_full)
	);

	initial
	begin
		clock = 1'b0;
		forever #4 clock = ~clock;   // 8 ns period
	end

	////////////////////////////////////////////////////////////
	// random source
	////////////////////////////////////////////////////////////
	// galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);   // one step for every bit taken
			r = {r[62:0], lfsr_state[0]};
		end
		return r;
	endfunction

	function automatic prf_cfg_pkg::prf_idx_t rand_idx();
		return prf_cfg_pkg::prf_idx_t'(rand_bits(prf_cfg_pkg::PRF_IDX_W));
	endfunction

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////
	// scan upward, the first free entry is pick one and the next is pick two
	function automatic prf_bus_pkg::rename_grants_t expect_grants(
		input prf_cfg_pkg::prf_mask_t free, input prf_bus_pkg::alloc_req_t req);
		prf_bus_pkg::rename_grants_t g;
		prf_bus_pkg::rename_grant_t  first;
		prf_bus_pkg::rename_grant_t  second;
		first  = '0;
		second = '0;
		g      = '0;
		for (int i = 0; i < prf_cfg_pkg::PRF_SIZE; i++)
		begin
			if (free[i] && !first.valid)
				first = '{valid: 1'b1, idx: prf_cfg_pkg::prf_idx_t'(i)};
			else if (free[i] && !second.valid)
				second = '{valid: 1'b1, idx: prf_cfg_pkg::prf_idx_t'(i)};
		end
		case (4'(req))
			4'b1100:
			begin
				g.rat1_slot1 = first;
				g.rat1_slot2 = second;
			end
			4'b0011:
			begin
				g.rat2_slot1 = first;
				g.rat2_slot2 = second;
			end
			4'b1010:
			begin
				g.rat1_slot1 = first;
				g.rat2_slot1 = second;
			end
			default:
				g = '0;
		endcase
		return g;
	endfunction

	function automatic prf_cfg_pkg::prf_mask_t granted_mask(input prf_bus_pkg::rename_grants_t g);
		prf_cfg_pkg::prf_mask_t m;
		m = '0;
		if (g.rat1_slot1.valid)
			m[g.rat1_slot1.idx] = 1'b1;
		if (g.rat1_slot2.valid)
			m[g.rat1_slot2.idx] = 1'b1;
		if (g.rat2_slot1.valid)
			m[g.rat2_slot1.idx] = 1'b1;
		if (g.rat2_slot2.valid)
			m[g.rat2_slot2.idx] = 1'b1;
		return m;
	endfunction

	// a valid recovery replaces the retire frees, recover2 before recover1
	function automatic prf_cfg_pkg::prf_mask_t expect_free_mask(
		input prf_bus_pkg::retire_free_t r1, input prf_bus_pkg::retire_free_t r2,
		input prf_bus_pkg::recover_t c1, input prf_bus_pkg::recover_t c2);
		prf_cfg_pkg::prf_mask_t m;
		m = '0;
		if (c2.valid)
			return c2.rrat_list & c2.rat_list;
		if (c1.valid)
			return c1.rrat_list & c1.rat_list;
		if (r1.valid)
			m[r1.idx] = 1'b1;
		if (r2.valid)
			m[r2.idx] = 1'b1;
		return m;
	endfunction

	function automatic prf_bus_pkg::operand_t expect_operand(input prf_cfg_pkg::prf_idx_t idx);
		prf_bus_pkg::operand_t op;
		op.valid = !free_m[idx] && ready_m[idx];
		if (op.valid)
			op.value = data_m[idx];
		else
			op.value = {{(prf_cfg_pkg::DATA_W-prf_cfg_pkg::PRF_IDX_W){1'b0}}, idx};
		return op;
	endfunction

	always_comb
	begin
		exp_grants     = expect_grants(free_m, alloc);
		exp_alloc_mask = granted_mask(exp_grants);
		exp_free_mask  = expect_free_mask(retire1, retire2, recover1, recover2);
		wr_mask        = '0;
		if (cdb1.valid)
			wr_mask[cdb1.tag] = 1'b1;
		if (cdb2.valid)
			wr_mask[cdb2.tag] = 1'b1;
		exp_opa1 = expect_operand(opa1_idx);
		exp_opb1 = expect_operand(opb1_idx);
		exp_opa2 = expect_operand(opa2_idx);
		exp_opb2 = expect_operand(opb2_idx);
	end

	// allocation beats a free, and a free beats a bus write
	always @(posedge clock)
	begin
		if (rst)
		begin
			free_m  <= '1;
			ready_m <= '0;
		end
		else
		begin
			free_m  <= (free_m | exp_free_mask) & ~exp_alloc_mask;
			ready_m <= (ready_m | wr_mask) & ~exp_free_mask & ~exp_alloc_mask;
			if (cdb1.valid && !exp_free_mask[cdb1.tag])
				data_m[cdb1.tag] <= cdb1.data;
			if (cdb2.valid && !exp_free_mask[cdb2.tag])
				data_m[cdb2.tag] <= cdb2.data;   // later write, so cdb2 keeps a shared tag
		end
	end

	////////////////////////////////////////////////////////////
	// checks on the falling edge, where every value has settled
	////////////////////////////////////////////////////////////
	task automatic abort_run();
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [127:0] exp,
		input logic [127:0] act);
		$display("FAIL time %0t %s expected %0h actual %0h", $time, name, exp, act);
		abort_run();
	endtask

	grants_match: assert property (@(negedge clock) disable iff (rst) grants == exp_grants)
		else report_mismatch("grants", 128'(exp_grants), 128'(grants));
	opa1_match: assert property (@(negedge clock) disable iff (rst) opa1 == exp_opa1)
		else report_mismatch("opa1", 128'(exp_opa1), 128'(opa1));
	opb1_match: assert property (@(negedge clock) disable iff (rst) opb1 == exp_opb1)
		else report_mismatch("opb1", 128'(exp_opb1), 128'(opb1));
	opa2_match: assert property (@(negedge clock) disable iff (rst) opa2 == exp_opa2)
		else report_mismatch("opa2", 128'(exp_opa2), 128'(opa2));
	opb2_match: assert property (@(negedge clock) disable iff (rst) opb2 == exp_opb2)
		else report_mismatch("opb2", 128'(exp_opb2), 128'(opb2));
	full_match: assert property (@(negedge clock) disable iff (rst)
		prf_is_full == (free_m == '0))
		else report_mismatch("prf_is_full", 128'(free_m == '0), 128'(prf_is_full));
	// the pool itself, so a refused pattern can not take an entry unseen
	pool_match: assert property (@(negedge clock) disable iff (rst) i_prf.free_bits == free_m)
		else report_mismatch("free_bits", 128'(free_m), 128'(i_prf.free_bits));

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////
	// one clock edge with every strobe dropped, callers add theirs after it
	task automatic step();
		@(posedge clock);
		alloc    <= '0;
		cdb1     <= '0;
		cdb2     <= '0;
		retire1  <= '0;
		retire2  <= '0;
		recover1 <= '0;
		recover2 <= '0;
	endtask

	task automatic read_at(input prf_cfg_pkg::prf_idx_t a1, input prf_cfg_pkg::prf_idx_t b1,
		input prf_cfg_pkg::prf_idx_t a2, input prf_cfg_pkg::prf_idx_t b2);
		opa1_idx <= a1;
		opb1_idx <= b1;
		opa2_idx <= a2;
		opb2_idx <= b2;
	endtask

	// first entry from start upward whose free bit equals want_free
	function automatic prf_cfg_pkg::prf_idx_t pick_entry(input prf_cfg_pkg::prf_idx_t start,
		input logic want_free);
		prf_cfg_pkg::prf_idx_t idx;
		idx = start;
		for (int n = 0; n < prf_cfg_pkg::PRF_SIZE; n++)
		begin
			if (free_m[idx] == want_free)
				return idx;
			idx = idx + 1'b1;
		end
		return start;
	endfunction

	initial
	begin
		prf_cfg_pkg::prf_idx_t tag_a;
		prf_cfg_pkg::prf_idx_t tag_b;
		int                    n;

		lfsr_state = 32'd84;
		rst        = 1'b1;
		cdb1       = '0;
		cdb2       = '0;
		alloc      = '0;
		retire1    = '0;
		retire2    = '0;
		recover1   = '0;
		recover2   = '0;
		opa1_idx   = '0;
		opb1_idx   = '0;
		opa2_idx   = '0;
		opb2_idx   = '0;
		repeat (2) @(posedge clock);
		rst <= 1'b0;

		// reset state, every read comes back with its own tag
		repeat (3)
		begin
			step();
			read_at(rand_idx(), rand_idx(), rand_idx(), rand_idx());
		end

		// accepted patterns twice each, then refused ones
		repeat (2)
		begin
			step();
			alloc <= 4'b1100;
			step();
			alloc <= 4'b0011;
			step();
			alloc <= 4'b1010;
		end
		step();
		alloc <= 4'b1111;
		step();
		alloc <= 4'b0110;
		repeat (6)
		begin
			step();
			alloc <= 4'(rand_bits(4));
			read_at(rand_idx(), rand_idx(), rand_idx(), rand_idx());
		end
		step();

		// bus writes to owned entries, read back from the next cycle on
		repeat (8)
		begin
			tag_a = pick_entry(rand_idx(), 1'b0);
			tag_b = pick_entry(rand_idx(), 1'b0);
			step();
			cdb1 <= '{valid: 1'b1, tag: tag_a, data: rand_bits(64)};
			cdb2 <= '{valid: 1'b1, tag: tag_b, data: rand_bits(64)};
			step();
			read_at(tag_a, tag_b, tag_b, tag_a);   // both results have landed by now
		end
		tag_a = pick_entry(rand_idx(), 1'b0);
		step();
		cdb1 <= '{valid: 1'b1, tag: tag_a, data: rand_bits(64)};
		cdb2 <= '{valid: 1'b1, tag: tag_a, data: rand_bits(64)};   // same tag on both buses
		read_at(tag_a, tag_a, tag_a, tag_a);
		tag_b = pick_entry(rand_idx(), 1'b1);
		step();
		cdb1 <= '{valid: 1'b1, tag: tag_b, data: rand_bits(64)};   // lands in a free entry
		read_at(tag_a, tag_b, tag_a, tag_b);
		step();

		// retire frees, then the freed entries go back out lowest first
		repeat (3)
		begin
			tag_a = pick_entry(rand_idx(), 1'b0);
			tag_b = pick_entry(rand_idx(), 1'b0);
			step();
			retire1 <= '{valid: 1'b1, idx: tag_a};
			retire2 <= '{valid: 1'b1, idx: tag_b};
			read_at(tag_a, tag_b, tag_a, tag_b);
			step();
			alloc <= 4'b1100;
			step();
		end

		// recovery alone, then both at once with recover2 in charge
		step();
		recover1 <= '{valid: 1'b1, rrat_list: rand_bits(64), rat_list: rand_bits(64)};
		read_at(rand_idx(), rand_idx(), rand_idx(), rand_idx());
		repeat (4)
		begin
			step();
			alloc <= 4'b0011;
		end
		step();
		recover1 <= '{valid: 1'b1, rrat_list: rand_bits(64), rat_list: rand_bits(64)};
		recover2 <= '{valid: 1'b1, rrat_list: rand_bits(64), rat_list: rand_bits(64)};
		step();

		// drain the pool, then one retire opens it again
		n = 0;
		while (!prf_is_full)
		begin
			if (n == 40)
			begin
				$display("timeout while allocating, the pool never became full");
				abort_run();
			end
			step();
			alloc <= 4'b1100;
			n++;
		end
		step();
		alloc <= 4'b1010;
		step();
		alloc <= 4'b0011;
		step();
		retire1 <= '{valid: 1'b1, idx: rand_idx()};
		repeat (2)
			step();
		alloc <= 4'b1010;
		repeat (3)
			step();

		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: hdl/prf.sv
////////////////////////////////////////////////////////////
// physical register file of the two thread core
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module prf (
	input  logic                        clock,
	input  logic                        rst,
	input  prf_bus_pkg::cdb_t           cdb1,
	input  prf_bus_pkg::cdb_t           cdb2,
	input  prf_cfg_pkg::prf_idx_t       opa1_idx,
	input  prf_cfg_pkg::prf_idx_t       opb1_idx,
	input  prf_cfg_pkg::prf_idx_t       opa2_idx,
	input  prf_cfg_pkg::prf_idx_t       opb2_idx,
	input  prf_bus_pkg::alloc_req_t     alloc,
	input  prf_bus_pkg::retire_free_t   retire1,
	input  prf_bus_pkg::retire_free_t   retire2,
	input  prf_bus_pkg::recover_t       recover1,    // rrat1 and rat2 lists
	input  prf_bus_pkg::recover_t       recover2,    // rrat2 and rat1 lists
	output prf_bus_pkg::rename_grants_t grants,
	output prf_bus_pkg::operand_t       opa1,
	output prf_bus_pkg::operand_t       opb1,
	output prf_bus_pkg::operand_t       opa2,
	output prf_bus_pkg::operand_t       opb2,
	output logic                        prf_is_full
);

	prf_cfg_pkg::prf_mask_t                             free_bits;    // array to allocator and reads
	prf_cfg_pkg::prf_mask_t                             ready_bits;
	prf_cfg_pkg::prf_mask_t                             alloc_mask;   // both granted picks
	prf_cfg_pkg::prf_mask_t                             free_mask;    // retire or recovery frees
	prf_cfg_pkg::prf_data_t [prf_cfg_pkg::PRF_SIZE-1:0] data;

	prf_free_alloc i_free_alloc (
		.free_bits  (free_bits),
		.alloc      (alloc),
		.grants     (grants),
		.alloc_mask (alloc_mask)
	);

	prf_free_ctrl i_free_ctrl (
		.retire1   (retire1),
		.retire2   (retire2),
		.recover1  (recover1),
		.recover2  (recover2),
		.free_mask (free_mask)
	);

	prf_entry_array i_entry_array (
		.clock      (clock),
		.rst        (rst),
		.cdb1       (cdb1),
		.cdb2       (cdb2),
		.alloc_mask (alloc_mask),
		.free_mask  (free_mask),
		.free_bits  (free_bits),
		.ready_bits (ready_bits),
		.data       (data)
	);

	prf_operand_read i_operand_read (
		.free_bits   (free_bits),
		.ready_bits  (ready_bits),
		.data        (data),
		.opa1_idx    (opa1_idx),
		.opb1_idx    (opb1_idx),
		.opa2_idx    (opa2_idx),
		.opb2_idx    (opb2_idx),
		.opa1        (opa1),
		.opb1        (opb1),
		.opa2        (opa2),
		.opb2        (opb2),
		.prf_is_full (prf_is_full)
	);

endmodule

`default_nettype wire

// File: hdl/prf_operand_read.sv
////////////////////////////////////////////////////////////
// operand read stage
// four ports that return a value or the tag still pending
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module prf_operand_read (
	input  prf_cfg_pkg::prf_mask_t                              free_bits,
	input  prf_cfg_pkg::prf_mask_t                              ready_bits,
	input  prf_cfg_pkg::prf_data_t [prf_cfg_pkg::PRF_SIZE-1:0]  data,
	input  prf_cfg_pkg::prf_idx_t                               opa1_idx,   // inst1 operand a
	input  prf_cfg_pkg::prf_idx_t                               opb1_idx,   // inst1 operand b
	input  prf_cfg_pkg::prf_idx_t                               opa2_idx,   // inst2 operand a
	input  prf_cfg_pkg::prf_idx_t                               opb2_idx,   // inst2 operand b
	output prf_bus_pkg::operand_t                               opa1,
	output prf_bus_pkg::operand_t                               opb1,
	output prf_bus_pkg::operand_t                               opa2,
	output prf_bus_pkg::operand_t                               opb2,
	output logic                                                prf_is_full
);

	// the single read rule, shared by every port
	// a hit needs the entry owned and written, a miss hands back its own tag
	function automatic prf_bus_pkg::operand_t read_port(input prf_cfg_pkg::prf_idx_t idx);
		prf_bus_pkg::operand_t op;
		op.valid = ready_bits[idx] && !free_bits[idx];
		if (op.valid)
			op.value = data[idx];
		else
			op.value = prf_cfg_pkg::prf_data_t'(idx);   // zero extended tag
		return op;
	endfunction

	////////////////////////////////////////////////////////////
	// ports
	////////////////////////////////////////////////////////////
	// the read rule looks at the state bits and data, so the block follows them too
	always_comb
	begin
		opa1 = read_port(opa1_idx);
		opb1 = read_port(opb1_idx);
		opa2 = read_port(opa2_idx);
		opb2 = read_port(opb2_idx);
	end

	// the pool is empty when not a single free bit is left
	assign prf_is_full = ~|free_bits;

endmodule

`default_nettype wire

// File: hdl/prf_entry_array.sv
////////////////////////////////////////////////////////////
// register entry array
// data, free and ready bits of every entry, plus bus write decode
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module prf_entry_array (
	input  logic                                                    clock,
	input  logic                                                    rst,
	input  prf_bus_pkg::cdb_t                                       cdb1,
	input  prf_bus_pkg::cdb_t                                       cdb2,
	input  prf_cfg_pkg::prf_mask_t                                  alloc_mask,
	input  prf_cfg_pkg::prf_mask_t                                  free_mask,
	output prf_cfg_pkg::prf_mask_t                                  free_bits,
	output prf_cfg_pkg::prf_mask_t                                  ready_bits,
	output prf_cfg_pkg::prf_data_t [prf_cfg_pkg::PRF_SIZE-1:0]      data
);

	prf_cfg_pkg::prf_mask_t                             free_q;    // high means in the pool
	prf_cfg_pkg::prf_mask_t                             ready_q;   // high means data is written
	prf_cfg_pkg::prf_data_t [prf_cfg_pkg::PRF_SIZE-1:0] data_q;
	prf_cfg_pkg::prf_mask_t                             wr_en;     // per entry bus hit
	prf_cfg_pkg::prf_data_t [prf_cfg_pkg::PRF_SIZE-1:0] wr_data;   // per entry bus value

	////////////////////////////////////////////////////////////
	// bus write decode
	////////////////////////////////////////////////////////////
	always_comb
	begin
		for (int i = 0; i < prf_cfg_pkg::PRF_SIZE; i++)
		begin
			wr_en[i]   = 1'b0;
			wr_data[i] = cdb1.data;   // default source, only used under wr_en
			if (cdb1.valid && (cdb1.tag == prf_cfg_pkg::prf_idx_t'(i)))
				wr_en[i] = 1'b1;
			if (cdb2.valid && (cdb2.tag == prf_cfg_pkg::prf_idx_t'(i)))
			begin
				wr_en[i]   = 1'b1;
				wr_data[i] = cdb2.data;   // cdb2 takes a tag both buses carry
			end
		end
	end

	////////////////////////////////////////////////////////////
	// state bits
	////////////////////////////////////////////////////////////
	// allocation only ever hits an entry that is already free, so it is
	// checked first and a free of that same entry changes nothing
	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			free_q  <= '1;   // whole pool is free
			ready_q <= '0;
		end
		else
		begin
			for (int i = 0; i < prf_cfg_pkg::PRF_SIZE; i++)
			begin
				if (alloc_mask[i])
				begin
					free_q[i]  <= 1'b0;
					ready_q[i] <= 1'b0;   // a fresh owner must wait for its own result
				end
				else if (free_mask[i])
				begin
					free_q[i]  <= 1'b1;
					ready_q[i] <= 1'b0;   // the free beats a bus write in the same cycle
				end
				else if (wr_en[i])
					ready_q[i] <= 1'b1;
			end
		end
	end

	// payload registers, the free and ready bits decide whether they mean anything
	always_ff @(posedge clock)
	begin
		for (int i = 0; i < prf_cfg_pkg::PRF_SIZE; i++)
		begin
			if (wr_en[i] && !free_mask[i])
				data_q[i] <= wr_data[i];
		end
	end

	assign free_bits  = free_q;
	assign ready_bits = ready_q;
	assign data       = data_q;

endmodule

`default_nettype wire

// File: hdl/prf_free_ctrl.sv
////////////////////////////////////////////////////////////
// free request decoder
// merges retire frees and recovery lists into one mask
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module prf_free_ctrl (
	input  prf_bus_pkg::retire_free_t retire1,     // retire free from thread 1
	input  prf_bus_pkg::retire_free_t retire2,     // retire free from thread 2
	input  prf_bus_pkg::recover_t     recover1,    // rrat1 list with the rat2 list
	input  prf_bus_pkg::recover_t     recover2,    // rrat2 list with the rat1 list
	output prf_cfg_pkg::prf_mask_t    free_mask    // entries returned to the pool next edge
);

	prf_cfg_pkg::prf_mask_t retire_mask;   // decoded retire indices

	// each retire index becomes a one hot bit, both can land in the same cycle
	always_comb
	begin
		retire_mask = '0;
		for (int i = 0; i < prf_cfg_pkg::PRF_SIZE; i++)
		begin
			if (retire1.valid && (retire1.idx == prf_cfg_pkg::prf_idx_t'(i)))
				retire_mask[i] = 1'b1;
			if (retire2.valid && (retire2.idx == prf_cfg_pkg::prf_idx_t'(i)))
				retire_mask[i] = 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// recovery override
	////////////////////////////////////////////////////////////
	// an entry is released only when it is dead for the squashed thread
	// and also not mapped by the rename table of the other thread
	always_comb
	begin
		free_mask = retire_mask;
		if (recover1.valid)
			free_mask = recover1.rrat_list & recover1.rat_list;
		if (recover2.valid)
			free_mask = recover2.rrat_list & recover2.rat_list;   // thread 2 recovery wins
	end

endmodule

`default_nettype wire

// File: hdl/prf_free_alloc.sv
////////////////////////////////////////////////////////////
// free register allocator
// picks the two lowest free entries and routes them to rename slots
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module prf_free_alloc (
	input  prf_cfg_pkg::prf_mask_t      free_bits,    // registered free bits of the array
	input  prf_bus_pkg::alloc_req_t     alloc,        // request strobes of both rename tables
	output prf_bus_pkg::rename_grants_t grants,       // same cycle answers to the requests
	output prf_cfg_pkg::prf_mask_t      alloc_mask    // entries that leave the pool next edge
);

	// keeps only the lowest set bit, zero in gives zero out
	function automatic prf_cfg_pkg::prf_mask_t lowest_one(input prf_cfg_pkg::prf_mask_t req);
		return req & (~req + 1'b1);
	endfunction

	// one hot to index, the OR only works because at most one bit is set
	function automatic prf_cfg_pkg::prf_idx_t onehot_idx(input prf_cfg_pkg::prf_mask_t onehot);
		prf_cfg_pkg::prf_idx_t idx;
		idx = '0;
		for (int i = 0; i < prf_cfg_pkg::PRF_SIZE; i++)
		begin
			if (onehot[i])
				idx = idx | prf_cfg_pkg::prf_idx_t'(i);
		end
		return idx;
	endfunction

	logic [3:0]                 pattern;        // request strobes as one vector
	logic                       picks_en;       // high only for the three accepted patterns
	prf_cfg_pkg::prf_mask_t     pick1;          // lowest free entry
	prf_cfg_pkg::prf_mask_t     free_after1;    // free bits with pick1 taken out
	prf_cfg_pkg::prf_mask_t     pick2;          // lowest free entry above pick1
	prf_bus_pkg::rename_grant_t grant1;
	prf_bus_pkg::rename_grant_t grant2;

	assign pattern  = alloc;
	assign picks_en = (pattern == 4'b1100) || (pattern == 4'b0011) || (pattern == 4'b1010);

	////////////////////////////////////////////////////////////
	// priority picks
	////////////////////////////////////////////////////////////
	assign pick1       = lowest_one(free_bits);
	assign free_after1 = free_bits & ~pick1;
	assign pick2       = lowest_one(free_after1);

	// a pick only turns into a grant when it exists and the pattern is legal
	assign grant1.valid = picks_en && (pick1 != '0);
	assign grant1.idx   = grant1.valid ? onehot_idx(pick1) : '0;
	assign grant2.valid = picks_en && (pick2 != '0);
	assign grant2.idx   = grant2.valid ? onehot_idx(pick2) : '0;

	// only granted picks are marked taken, so a short pool never loses an entry
	assign alloc_mask = (grant1.valid ? pick1 : '0) | (grant2.valid ? pick2 : '0);

	////////////////////////////////////////////////////////////
	// slot routing
	////////////////////////////////////////////////////////////
	always_comb
	begin
		grants = '0;   // slots that are not routed stay invalid with index zero
		case (pattern)
			4'b1100:
			begin
				grants.rat1_slot1 = grant1;
				grants.rat1_slot2 = grant2;
			end
			4'b0011:
			begin
				grants.rat2_slot1 = grant1;
				grants.rat2_slot2 = grant2;
			end
			4'b1010:
			begin
				grants.rat1_slot1 = grant1;   // each thread gets one register on its first slot
				grants.rat2_slot1 = grant2;
			end
			default:
			begin
				grants = '0;   // any other mix of strobes is refused as a whole
			end
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/prf_bus_pkg.sv
////////////////////////////////////////////////////////////
// bundles that cross the register file boundary
// result buses, rename requests and grants, reads and frees
////////////////////////////////////////////////////////////
`default_nettype none

package prf_bus_pkg;

	// one common data bus, the tag names the entry the result lands in
	typedef struct packed {
		logic                  valid;
		prf_cfg_pkg::prf_idx_t tag;
		prf_cfg_pkg::prf_data_t data;
	} cdb_t;

	// request strobes, rat1 slot 1 sits in the top bit so the vector reads 1100 for rat1
	typedef struct packed {
		logic rat1_slot1;
		logic rat1_slot2;
		logic rat2_slot1;
		logic rat2_slot2;
	} alloc_req_t;

	typedef struct packed {
		logic                  valid;   // low when no free entry was found or the pattern is bad
		prf_cfg_pkg::prf_idx_t idx;     // zero whenever valid is low
	} rename_grant_t;

	// same slot order as alloc_req_t
	typedef struct packed {
		rename_grant_t rat1_slot1;
		rename_grant_t rat1_slot2;
		rename_grant_t rat2_slot1;
		rename_grant_t rat2_slot2;
	} rename_grants_t;

	typedef struct packed {
		logic                   valid;   // high means value holds real data
		prf_cfg_pkg::prf_data_t value;   // otherwise the zero extended tag to wait on
	} operand_t;

	// a register released by a retiring instruction
	typedef struct packed {
		logic                  valid;
		prf_cfg_pkg::prf_idx_t idx;
	} retire_free_t;

	// mispredict recovery, entries set in both lists are given back to the pool
	typedef struct packed {
		logic                   valid;
		prf_cfg_pkg::prf_mask_t rrat_list;   // list from the retirement table of the thread
		prf_cfg_pkg::prf_mask_t rat_list;    // list from the rename table of the other thread
	} recover_t;

endpackage

`default_nettype wire

// File: hdl/prf_cfg_pkg.sv
////////////////////////////////////////////////////////////
// physical register file sizing
// widths and plain vector types shared by every block
////////////////////////////////////////////////////////////
`default_nettype none

package prf_cfg_pkg;

	// both threads draw from this one pool of physical registers
	localparam int PRF_SIZE  = 64;

	localparam int PRF_IDX_W = $clog2(PRF_SIZE);   // bits needed to name one entry
	localparam int DATA_W    = 64;                 // width of one register value

	// a physical register tag, also the pending tag handed back on a miss
	typedef logic [PRF_IDX_W-1:0] prf_idx_t;

	typedef logic [PRF_SIZE-1:0]  prf_mask_t;   // one bit per entry, bit i is entry i
	typedef logic [DATA_W-1:0]    prf_data_t;   // one register value

endpackage

`default_nettype wire
